// ==== devices.f ====
common/devices_pkg.sv
verilog/io_decoder.sv
tone_slot/tone_slot.sv
verilog/device_mixer.sv
verilog/devices.sv
verif/devices_props.sv
verif/devices_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the devices testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module devices_tb \
    -f devices.f \
    -Mdir obj_dir \
    && ./obj_dir/Vdevices_tb \
    || { echo "Simulation failed"; exit 1; }

// ==== verif/devices_tb.sv ====
`timescale 1ns/1ps

module devices_tb;

    localparam int NUM_SLOTS  = 10;             // Enough full-volume slots to clip.
    localparam int N_RESET    = NUM_SLOTS * 4;
    localparam int N_WRITE    = 48;
    localparam int N_READ     = 48;
    localparam int N_DECODE   = 40;
    localparam int N_BP       = 64;
    localparam int N_QUIET    = NUM_SLOTS * 3;
    localparam int N_TONE     = NUM_SLOTS * 4;
    localparam int TOTAL_REQS = N_RESET + N_WRITE + N_READ + N_DECODE + N_BP + N_QUIET + N_TONE;
    localparam int MAX_CYCLES = TOTAL_REQS * 8 + 100;

    logic                    clk;
    logic                    arst_n;
    logic                    req_valid;
    logic                    req_ready;
    devices_pkg::io_req_t    req;
    devices_pkg::io_device_t io_table [NUM_SLOTS];
    logic                    rsp_valid;
    logic                    rsp_ready;
    devices_pkg::io_rsp_t    rsp;
    logic signed [15:0]      sound;

    logic [31:0]          lfsr;
    int                   cycles = 0;
    string                test_name;
    logic                 bp_on;
    logic                 req_done;             // Current request taken at the last edge.
    devices_pkg::io_req_t pending [$];
    logic [8:0]           expected [$];         // {rdata, hit} in request order.
    logic [7:0]           m_reg [NUM_SLOTS][4]; // Read-back value per slot and index.

    devices #(
        .NUM_SLOTS(NUM_SLOTS)
    ) dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req      (req),
        .io_table (io_table),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp      (rsp),
        .sound    (sound)
    );

    bind devices devices_props u_props (
        .clk      (clk),
        .arst_n   (arst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req      (req),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp      (rsp),
        .cmd_valid(cmd_valid)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles.", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped by timeout.");
        end
    end

    task automatic report_mismatch(input string test, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("[ERROR] %s: expected %h, actual %h", test, want, got);
        $display("TEST FAILED");
        $fatal(1, "Stopping on first error.");
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        $display("TEST FAILED");
        $fatal(1, "Stopping on first error.");
    endtask

    // Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int rand_slot();
        return int'(rand_bits(8)) % NUM_SLOTS;
    endfunction

    function automatic logic [7:0] slot_port(input int k, input int idx);
        return 8'h40 + 8'(4 * k + idx);
    endfunction

    function automatic int clamp16(input int v);
        if (v > 32767) begin
            return 32767;
        end
        if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    // Entries whose masked base agrees with the port.
    function automatic logic [NUM_SLOTS-1:0] model_match(input logic [7:0] port);
        logic [NUM_SLOTS-1:0] m;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            m[k] = io_table[k].enable &&
                   ((port & io_table[k].mask) == (io_table[k].base & io_table[k].mask));
        end
        return m;
    endfunction

    function automatic int quiet_sound();
        int sum;
        sum = 0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            sum += int'(m_reg[k][2]) * 256;
        end
        return clamp16(sum);
    endfunction

    // True when some sign pattern over the slots gives this clipped sum.
    function automatic logic sound_allowed(input logic signed [15:0] s);
        int  sum;
        logic ok;
        ok = 1'b0;
        for (int c = 0; c < (1 << NUM_SLOTS); c++) begin
            sum = 0;
            for (int k = 0; k < NUM_SLOTS; k++) begin
                sum += c[k] ? -int'(m_reg[k][2]) * 256 : int'(m_reg[k][2]) * 256;
            end
            if (clamp16(sum) == int'(s)) begin
                ok = 1'b1;
            end
        end
        return ok;
    endfunction

    task automatic model_accept(input devices_pkg::io_req_t r);
        logic [NUM_SLOTS-1:0] m;
        logic [7:0]           data;
        int                   idx;
        m    = model_match(r.port);
        idx  = int'(r.port[1:0]);
        data = 8'hFF;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            if (m[k] && r.op == devices_pkg::IO_WRITE) begin
                m_reg[k][idx] = (idx == 1 || idx == 2) ? {4'h0, r.wdata[3:0]} : r.wdata;
            end else if (m[k]) begin
                data = data & m_reg[k][idx];
            end
        end
        if (r.op == devices_pkg::IO_READ) begin
            expected.push_back({data, |m});
        end
    endtask

    task automatic queue_req(input devices_pkg::io_op_t op, input logic [7:0] port,
                             input logic [7:0] wdata);
        devices_pkg::io_req_t r;
        r.op    = op;
        r.port  = port;
        r.wdata = wdata;
        pending.push_back(r);
    endtask

    task automatic queue_random(input devices_pkg::io_op_t op);
        int          s;
        int          idx;
        logic [31:0] r;
        s   = rand_slot();
        idx = int'(rand_bits(2));
        r   = rand_bits(8);
        queue_req(op, slot_port(s, idx), r[7:0]);
    endtask

    task automatic load_table(input logic decode_mix);
        for (int k = 0; k < NUM_SLOTS; k++) begin
            io_table[k].enable = 1'b1;
            io_table[k].base   = slot_port(k, 0);
            io_table[k].mask   = 8'hFC;
        end
        if (decode_mix) begin
            io_table[1].enable         = 1'b0;   // Disabled entry at 0x44.
            io_table[NUM_SLOTS-2].base = 8'h80;  // Overlap on 0x80 to 0x83.
            io_table[NUM_SLOTS-1].base = 8'h80;
            io_table[NUM_SLOTS-1].mask = 8'hF0;
        end
    endtask

    // Drives queued requests and checks responses until both sides are empty.
    task automatic run_queue();
        devices_pkg::io_rsp_t held;
        logic                 held_valid;
        logic [8:0]           want;
        logic [31:0]          r;
        held_valid = 1'b0;
        held       = '0;
        while (pending.size() > 0 || req_valid || expected.size() > 0) begin
            @(negedge clk);
            if (req_done) begin
                req_valid = 1'b0;
                req_done  = 1'b0;
            end
            if (!req_valid && pending.size() > 0) begin
                req       = pending.pop_front();
                req_valid = 1'b1;
            end
            r         = rand_bits(1);
            rsp_ready = !bp_on || r[0];
            #1;
            if (held_valid) begin
                assert (rsp_valid && rsp == held)
                    else report_mismatch(test_name, 32'(held), 32'(rsp));
            end
            if (rsp_valid && rsp_ready) begin
                assert (expected.size() > 0)
                    else report_failure("Response arrived with no read outstanding.");
                want = expected.pop_front();
                assert ({rsp.rdata, rsp.hit} == want)
                    else report_mismatch(test_name, 32'(want), 32'({rsp.rdata, rsp.hit}));
            end
            held_valid = rsp_valid && !rsp_ready;
            held       = rsp;
            if (req_valid && req_ready) begin
                model_accept(req);
                req_done = 1'b1;
            end
        end
        repeat (2) begin
            @(negedge clk);
            rsp_ready = 1'b1;
            #1;
            assert (!rsp_valid) else report_failure("Extra response after all reads completed.");
        end
    endtask

    initial begin
        logic [31:0] r;
        lfsr      = 32'hed38;
        arst_n    = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        bp_on     = 1'b0;
        req_done  = 1'b0;
        test_name = "reset";
        for (int k = 0; k < NUM_SLOTS; k++) begin
            for (int i = 0; i < 4; i++) begin
                m_reg[k][i] = 8'h00;
            end
        end
        load_table(1'b0);
        #1;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        assert (!rsp_valid) else report_failure("rsp_valid high after reset.");
        assert (req_ready) else report_failure("req_ready low after reset.");
        assert (sound == 16'sd0) else report_mismatch(test_name, 32'd0, 32'(sound));
        for (int k = 0; k < NUM_SLOTS; k++) begin
            for (int i = 0; i < 4; i++) begin
                queue_req(devices_pkg::IO_READ, slot_port(k, i), 8'h00);
            end
        end
        run_queue();

        test_name = "readback";
        repeat (N_WRITE) queue_random(devices_pkg::IO_WRITE);
        repeat (N_READ) queue_random(devices_pkg::IO_READ);
        run_queue();

        test_name = "decode";
        load_table(1'b1);
        for (int n = 0; n < N_DECODE - 1; n++) begin
            r = rand_bits(10);
            case (r[9:8])
                2'd0:    queue_req(devices_pkg::IO_READ, r[7:0], 8'h00);       // Anywhere.
                2'd1:    queue_req(devices_pkg::IO_READ, 8'h44 + 8'(r[1:0]), 8'h00);
                2'd2:    queue_req(devices_pkg::IO_READ, 8'h80 + 8'(r[1:0]), 8'h00);
                default: queue_req(devices_pkg::IO_READ, 8'h84 + 8'(r[2:0]), 8'h00);
            endcase
        end
        queue_req(devices_pkg::IO_READ, 8'hF0, 8'h00);
        run_queue();
        load_table(1'b0);

        test_name = "backpressure";
        bp_on = 1'b1;
        for (int n = 0; n < N_BP; n++) begin
            r = rand_bits(1);
            queue_random(devices_pkg::io_op_t'(r[0]));
        end
        run_queue();
        bp_on = 1'b0;

        test_name = "quiet_sound";
        for (int k = 0; k < NUM_SLOTS; k++) begin
            queue_req(devices_pkg::IO_WRITE, slot_port(k, 3), 8'h00);
        end
        for (int k = 0; k < NUM_SLOTS; k++) begin
            r = rand_bits(4);
            queue_req(devices_pkg::IO_WRITE, slot_port(k, 2), r[7:0]);
        end
        run_queue();
        @(negedge clk);
        #1;
        assert (int'(sound) == quiet_sound())
            else report_mismatch(test_name, 32'(quiet_sound()), 32'(sound));
        for (int k = 0; k < NUM_SLOTS; k++) begin
            queue_req(devices_pkg::IO_WRITE, slot_port(k, 2), 8'h0F);
        end
        run_queue();
        @(negedge clk);
        #1;
        assert (int'(sound) == 32767) else report_mismatch(test_name, 32'd32767, 32'(sound));

        test_name = "tone_sound";
        for (int k = 0; k < NUM_SLOTS; k++) begin
            r = rand_bits(15);
            queue_req(devices_pkg::IO_WRITE, slot_port(k, 0), 8'(r[2:0]) + 8'd1);
            queue_req(devices_pkg::IO_WRITE, slot_port(k, 1), 8'h00);
            queue_req(devices_pkg::IO_WRITE, slot_port(k, 2), {4'h0, r[6:3]});
            queue_req(devices_pkg::IO_WRITE, slot_port(k, 3), {r[14:8], 1'b1});
        end
        run_queue();
        repeat (4) @(negedge clk);
        repeat (64) begin
            @(negedge clk);
            #1;
            assert (sound_allowed(sound))
                else report_failure($sformatf("Sound %0d is no sum of slot amplitudes.", sound));
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== verif/devices_props.sv ====
`timescale 1ns/1ps

module devices_props (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 req_valid,
    input logic                 req_ready,
    input devices_pkg::io_req_t req,
    input logic                 rsp_valid,
    input logic                 rsp_ready,
    input devices_pkg::io_rsp_t rsp,
    input logic                 cmd_valid
);

    // A waiting request keeps its payload until taken.
    req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("Request dropped or changed while waiting for req_ready.");

    // A held response stays put until drained.
    rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("Response dropped or changed while waiting for rsp_ready.");

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !rsp_valid && !cmd_valid)
        else $error("Valid signal high during reset.");

endmodule

// ==== verilog/devices.sv ====
`timescale 1ns/1ps

module devices #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  devices_pkg::io_req_t    req,
    input  devices_pkg::io_device_t io_table [NUM_SLOTS],  // One entry per slot.
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output devices_pkg::io_rsp_t    rsp,
    output logic signed [15:0]      sound
);

    logic                   cmd_valid;
    logic                   cmd_ready;
    devices_pkg::slot_cmd_t cmd;
    logic [NUM_SLOTS-1:0]   sel;
    logic [7:0]             slot_rdata [NUM_SLOTS];
    logic signed [15:0]     slot_sample [NUM_SLOTS];

    io_decoder #(
        .NUM_SLOTS(NUM_SLOTS)
    ) u_decoder (
        .clk      (clk),
        .arst_n   (arst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req      (req),
        .io_table (io_table),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd      (cmd),
        .sel      (sel)
    );

    // Identical tone devices sharing the command broadcast.
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        tone_slot u_slot (
            .clk      (clk),
            .arst_n   (arst_n),
            .cmd_valid(cmd_valid),
            .cmd_ready(cmd_ready),
            .cmd      (cmd),
            .selected (sel[i]),
            .rdata    (slot_rdata[i]),
            .sample   (slot_sample[i])
        );
    end

    device_mixer #(
        .NUM_SLOTS(NUM_SLOTS)
    ) u_mixer (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .sel        (sel),
        .slot_rdata (slot_rdata),
        .slot_sample(slot_sample),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .sound      (sound)
    );

endmodule

// ==== verilog/device_mixer.sv ====
`timescale 1ns/1ps

module device_mixer #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  devices_pkg::slot_cmd_t cmd,
    input  logic [NUM_SLOTS-1:0]   sel,
    input  logic [7:0]             slot_rdata [NUM_SLOTS],
    input  logic signed [15:0]     slot_sample [NUM_SLOTS],
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output devices_pkg::io_rsp_t   rsp,
    output logic signed [15:0]     sound
);

    localparam int SUM_W = 16 + $clog2(NUM_SLOTS + 1);

    logic [7:0]              bus_data;
    logic                    is_read;
    logic                    rsp_load;
    logic signed [SUM_W-1:0] sum;
    logic signed [15:0]      sum_sat;

    // Open bus stays high unless some slot pulls a bit low.
    always_comb begin
        bus_data = devices_pkg::OPEN_BUS;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            bus_data = bus_data & slot_rdata[i];
        end
    end

    assign is_read = (cmd.op == devices_pkg::IO_READ);

    // Writes never wait, reads need a free or draining response register.
    assign cmd_ready = !is_read || !rsp_valid || rsp_ready;
    assign rsp_load  = cmd_valid && is_read && cmd_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (rsp_load) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_load) begin
            rsp.rdata <= bus_data;
            rsp.hit   <= |sel;  // Any match counts.
        end
    end

    // Wide sum then clamp to 16-bit signed.
    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            sum = sum + SUM_W'(slot_sample[i]);
        end
        if (sum > SUM_W'(32767)) begin
            sum_sat = 16'sh7FFF;
        end else if (sum < -SUM_W'(32768)) begin
            sum_sat = -16'sh8000;
        end else begin
            sum_sat = sum[15:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sound <= 16'sd0;
        end else begin
            sound <= sum_sat;
        end
    end

endmodule

// ==== tone_slot/tone_slot.sv ====
`timescale 1ns/1ps

module tone_slot (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   cmd_valid,
    input  logic                   cmd_ready,
    input  devices_pkg::slot_cmd_t cmd,
    input  logic                   selected,
    output logic [7:0]             rdata,
    output logic signed [15:0]     sample
);

    logic [7:0]         period_lo;
    logic [3:0]         period_hi;
    logic [3:0]         volume;
    logic [7:0]         control;
    logic [11:0]        period;
    logic [11:0]        count;
    logic               phase;      // High means negative half.
    logic               tone_on;
    logic               wr_en;
    logic signed [15:0] amp;

    assign period  = {period_hi, period_lo};
    assign tone_on = control[0] && (period != 12'd0);

    assign wr_en = cmd_valid && cmd_ready && selected &&
                   (cmd.op == devices_pkg::IO_WRITE);

    // Register file.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            period_lo <= 8'h00;
            period_hi <= 4'h0;
            volume    <= 4'h0;
            control   <= 8'h00;
        end else if (wr_en) begin
            case (cmd.idx)
                devices_pkg::REG_PERIOD_LO: period_lo <= cmd.wdata;
                devices_pkg::REG_PERIOD_HI: period_hi <= cmd.wdata[3:0];
                devices_pkg::REG_VOLUME:    volume    <= cmd.wdata[3:0];
                devices_pkg::REG_CONTROL:   control   <= cmd.wdata;
            endcase
        end
    end

    // Square wave with a half period of period + 1 clocks.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= 12'd0;
            phase <= 1'b0;
        end else if (!tone_on) begin
            count <= 12'd0;
            phase <= 1'b0;  // Hold positive while idle.
        end else if (count == 12'd0) begin
            count <= period;
            phase <= ~phase;
        end else begin
            count <= count - 12'd1;
        end
    end

    assign amp = 16'(volume) << devices_pkg::VOL_SHIFT;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample <= 16'sd0;
        end else begin
            sample <= phase ? -amp : amp;
        end
    end

    // Read-back of the addressed register.
    always_comb begin
        if (!selected) begin
            rdata = devices_pkg::OPEN_BUS;  // Bus left floating for other slots.
        end else begin
            case (cmd.idx)
                devices_pkg::REG_PERIOD_LO: rdata = period_lo;
                devices_pkg::REG_PERIOD_HI: rdata = {4'h0, period_hi};
                devices_pkg::REG_VOLUME:    rdata = {4'h0, volume};
                devices_pkg::REG_CONTROL:   rdata = control;
                default:                    rdata = devices_pkg::OPEN_BUS;
            endcase
        end
    end

endmodule

// ==== verilog/io_decoder.sv ====
`timescale 1ns/1ps

module io_decoder #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  devices_pkg::io_req_t   req,
    input  devices_pkg::io_device_t io_table [NUM_SLOTS],
    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    output devices_pkg::slot_cmd_t cmd,
    output logic [NUM_SLOTS-1:0]   sel
);

    logic                   st_valid;   // Stage holds a request.
    devices_pkg::slot_cmd_t st_cmd;
    logic [NUM_SLOTS-1:0]   st_sel;
    logic [NUM_SLOTS-1:0]   match;
    devices_pkg::slot_cmd_t next_cmd;
    logic                   req_fire;

    // Masked compare of the port against every table entry.
    always_comb begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            match[k] = io_table[k].enable &&
                       (((req.port ^ io_table[k].base) & io_table[k].mask) == 8'h00);
        end
    end

    // Translate the CPU request into a slot command.
    always_comb begin
        next_cmd.op    = req.op;
        next_cmd.idx   = devices_pkg::reg_idx_t'(req.port[1:0]);
        next_cmd.wdata = req.wdata;
    end

    // Stage frees up in the same cycle the mixer takes the command.
    assign req_ready = !st_valid || cmd_ready;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_valid <= 1'b0;
        end else if (req_fire) begin
            st_valid <= 1'b1;
        end else if (cmd_ready) begin
            st_valid <= 1'b0;  // Drained without refill.
        end
    end

    // Payload only loads on acceptance.
    always_ff @(posedge clk) begin
        if (req_fire) begin
            st_cmd <= next_cmd;
            st_sel <= match;
        end
    end

    assign cmd_valid = st_valid;
    assign cmd       = st_cmd;
    assign sel       = st_sel;

endmodule

// ==== common/devices_pkg.sv ====
package devices_pkg;

    // CPU side port operation.
    typedef enum logic {
        IO_READ  = 1'b0,
        IO_WRITE = 1'b1
    } io_op_t;

    // Register index inside a tone slot, taken from the two low port bits.
    typedef enum logic [1:0] {
        REG_PERIOD_LO = 2'd0,  // Period bits 7:0.
        REG_PERIOD_HI = 2'd1,  // Period bits 11:8 in the low nibble.
        REG_VOLUME    = 2'd2,  // 4-bit volume.
        REG_CONTROL   = 2'd3   // Bit 0 enables the tone.
    } reg_idx_t;

    // Request from the CPU side.
    typedef struct packed {
        io_op_t     op;
        logic [7:0] port;
        logic [7:0] wdata;
    } io_req_t;

    // Read response back to the CPU side.
    typedef struct packed {
        logic [7:0] rdata;
        logic       hit;    // Some enabled entry matched.
    } io_rsp_t;

    // One entry of the port decode table.
    typedef struct packed {
        logic       enable;
        logic [7:0] base;
        logic [7:0] mask;   // Set bits must agree with base.
    } io_device_t;

    // Command broadcast by the decoder to every slot.
    typedef struct packed {
        io_op_t     op;
        reg_idx_t   idx;
        logic [7:0] wdata;
    } slot_cmd_t;

    // Value seen on the data bus when nothing drives it.
    localparam logic [7:0] OPEN_BUS = 8'hFF;

    // Sample amplitude is volume shifted left by this amount.
    localparam int VOL_SHIFT = 8;

endpackage
